//--- src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

   // ============================================================
   // Widths and sizes
   // ============================================================
   localparam int XLEN          = 32;
   localparam int TAG_W         = 5;
   localparam int ROB_W         = 4;
   localparam int SCHED_ENTRIES = 4;
   // Wide enough that live entries never span a full counter wrap
   localparam int AGE_W         = 6;

   typedef enum logic {
      LOAD  = 1'b0,
      STORE = 1'b1
   } lsu_op_e;

   typedef enum logic [1:0] {
      NONE         = 2'd0,
      MISALIGNED   = 2'd1,
      ACCESS_FAULT = 2'd2
   } lsu_exc_e;

   // ============================================================
   // Payloads
   // ============================================================
   typedef struct packed {
      logic             ready;
      logic [TAG_W-1:0] tag;
      logic [XLEN-1:0]  value;
   } reg_src_t;

   typedef struct packed {
      lsu_op_e          op;
      logic [ROB_W-1:0] rob_id;
      logic [TAG_W-1:0] rd_tag;
      reg_src_t         rs1;
      reg_src_t         rs2;
      logic [11:0]      imm;     // two's complement
   } lsu_disp_t;

   typedef struct packed {
      lsu_op_e          op;
      logic [ROB_W-1:0] rob_id;
      logic [TAG_W-1:0] rd_tag;
      logic [XLEN-1:0]  base;
      logic [XLEN-1:0]  st_data;
      logic [11:0]      imm;
   } lsu_issue_t;

   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
      logic [XLEN-1:0]  data;
   } phy_wr_t;

   typedef struct packed {
      logic [XLEN-1:0] addr;
      logic            write;
      logic [XLEN-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic [XLEN-1:0] rdata;
      logic            err;
   } mem_resp_t;

   typedef struct packed {
      logic             valid;
      logic [ROB_W-1:0] rob_id;
      lsu_exc_e         exc;
   } lsu_done_t;

endpackage

`default_nettype wire

//--- src/lsu_sched.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_sched (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_disp_valid,
   input  lsu_pkg::lsu_disp_t   i_disp,
   output logic                 o_disp_ready,
   input  lsu_pkg::phy_wr_t     i_phy_wr,
   input  lsu_pkg::phy_wr_t     i_self_wr,
   output logic                 o_issue_valid,
   output lsu_pkg::lsu_issue_t  o_issue,
   input  logic                 i_issue_ready
);
   import lsu_pkg::*;

   lsu_disp_t                ent_q [SCHED_ENTRIES];
   logic [AGE_W-1:0]         age_q [SCHED_ENTRIES];
   logic [SCHED_ENTRIES-1:0] vld_q;
   logic [AGE_W-1:0]         alloc_cnt_q;

   logic [SCHED_ENTRIES-1:0] free_oh;
   logic [SCHED_ENTRIES-1:0] rdy_vec;
   logic [SCHED_ENTRIES-1:0] pick_oh;
   logic [SCHED_ENTRIES-1:0] issue_oh;
   logic [AGE_W-1:0]         age_dist [SCHED_ENTRIES];
   logic                     disp_fire;
   lsu_disp_t                disp_woke;

   // Capture from whichever broadcast carries the pending tag
   function automatic reg_src_t wake_src(input reg_src_t src, input phy_wr_t wr_a,
                                         input phy_wr_t wr_b);
      reg_src_t res;
      res = src;
      if (!src.ready && wr_a.valid && wr_a.tag == src.tag) begin
         res.ready = 1'b1;
         res.value = wr_a.data;
      end else if (!src.ready && wr_b.valid && wr_b.tag == src.tag) begin
         res.ready = 1'b1;
         res.value = wr_b.data;
      end
      return res;
   endfunction

   // Lowest free entry, zero when full
   assign free_oh      = ~vld_q & (vld_q + 1'b1);
   assign o_disp_ready = |free_oh;
   assign disp_fire    = i_disp_valid && o_disp_ready;

   always_comb begin
      disp_woke     = i_disp;
      disp_woke.rs1 = wake_src(i_disp.rs1, i_phy_wr, i_self_wr);
      disp_woke.rs2 = wake_src(i_disp.rs2, i_phy_wr, i_self_wr);
   end

   // ============================================================
   // Oldest-ready select
   // ============================================================
   always_comb begin
      for (int i = 0; i < SCHED_ENTRIES; i++) begin
         age_dist[i] = alloc_cnt_q - age_q[i];
         // Loads never read rs2
         rdy_vec[i]  = vld_q[i] && ent_q[i].rs1.ready &&
                       (ent_q[i].rs2.ready || ent_q[i].op == LOAD);
      end
   end

   always_comb begin : pick_oldest
      logic [AGE_W-1:0] best_dist;
      logic             found;
      best_dist = '0;
      found     = 1'b0;
      pick_oh   = '0;
      for (int i = 0; i < SCHED_ENTRIES; i++) begin
         if (rdy_vec[i] && (!found || age_dist[i] > best_dist)) begin
            found      = 1'b1;
            best_dist  = age_dist[i];
            pick_oh    = '0;
            pick_oh[i] = 1'b1;
         end
      end
   end

   always_comb begin
      o_issue = '0;
      for (int i = 0; i < SCHED_ENTRIES; i++) begin
         if (pick_oh[i]) begin
            o_issue.op      = ent_q[i].op;
            o_issue.rob_id  = ent_q[i].rob_id;
            o_issue.rd_tag  = ent_q[i].rd_tag;
            o_issue.base    = ent_q[i].rs1.value;
            o_issue.st_data = ent_q[i].rs2.value;
            o_issue.imm     = ent_q[i].imm;
         end
      end
   end

   assign o_issue_valid = |rdy_vec;
   assign issue_oh      = pick_oh & {SCHED_ENTRIES{i_issue_ready}};

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         vld_q       <= '0;
         alloc_cnt_q <= '0;
      end else begin
         vld_q <= (vld_q & ~issue_oh) | (disp_fire ? free_oh : '0);
         if (disp_fire) begin
            alloc_cnt_q <= alloc_cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      for (int i = 0; i < SCHED_ENTRIES; i++) begin
         if (disp_fire && free_oh[i]) begin
            ent_q[i] <= disp_woke;
            age_q[i] <= alloc_cnt_q;
         end else begin
            ent_q[i].rs1 <= wake_src(ent_q[i].rs1, i_phy_wr, i_self_wr);
            ent_q[i].rs2 <= wake_src(ent_q[i].rs2, i_phy_wr, i_self_wr);
         end
      end
   end

   // While full and nothing leaves, no allocation may happen
   a_no_disp_full: assert property (@(posedge i_clk) disable iff (i_rst)
      (&vld_q && !(|issue_oh)) |=> (&vld_q && $stable(alloc_cnt_q)));

   a_issue_entry: assert property (@(posedge i_clk) disable iff (i_rst)
      (o_issue_valid && i_issue_ready) |->
         ($onehot(issue_oh & rdy_vec) ##1 !(|(vld_q & $past(issue_oh)))));

endmodule

`default_nettype wire

//--- src/lsu_pipe.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_pipe (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_issue_valid,
   input  lsu_pkg::lsu_issue_t  i_issue,
   output logic                 o_ex0_ready,
   output logic                 o_mem_req_valid,
   output lsu_pkg::mem_req_t    o_mem_req,
   input  logic                 i_resp_valid,
   input  lsu_pkg::mem_resp_t   i_resp,
   output lsu_pkg::phy_wr_t     o_ex3_phy_wr,
   output lsu_pkg::lsu_done_t   o_done
);
   import lsu_pkg::*;

   typedef struct packed {
      lsu_op_e          op;
      logic [ROB_W-1:0] rob_id;
      logic [TAG_W-1:0] rd_tag;
      logic [XLEN-1:0]  addr;
      logic [XLEN-1:0]  st_data;
      logic             misal;
   } ex2_t;

   typedef struct packed {
      lsu_op_e          op;
      logic [ROB_W-1:0] rob_id;
      logic [TAG_W-1:0] rd_tag;
      logic [XLEN-1:0]  data;
      lsu_exc_e         exc;
   } ex3_t;

   logic       ex0_vld_q, ex1_vld_q, ex2_vld_q, ex3_vld_q;
   lsu_issue_t ex0_q, ex1_q;
   ex2_t       ex2_q, ex1_ex2;
   ex3_t       ex3_q;

   logic       ex2_adv;
   logic       ex2_free;
   logic       ex1_free;
   logic [XLEN-1:0] ex1_addr;

   // ============================================================
   // Flow control
   // ============================================================
   assign ex2_adv     = ex2_vld_q && (ex2_q.misal || i_resp_valid);
   assign ex2_free    = !ex2_vld_q || ex2_adv;
   assign ex1_free    = !ex1_vld_q || ex2_free;
   assign o_ex0_ready = !ex0_vld_q || ex1_free;

   // Address generation
   assign ex1_addr = ex1_q.base + {{(XLEN-12){ex1_q.imm[11]}}, ex1_q.imm};

   always_comb begin
      ex1_ex2.op      = ex1_q.op;
      ex1_ex2.rob_id  = ex1_q.rob_id;
      ex1_ex2.rd_tag  = ex1_q.rd_tag;
      ex1_ex2.addr    = ex1_addr;
      ex1_ex2.st_data = ex1_q.st_data;
      ex1_ex2.misal   = |ex1_addr[1:0];
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ex0_vld_q <= 1'b0;
         ex1_vld_q <= 1'b0;
         ex2_vld_q <= 1'b0;
         ex3_vld_q <= 1'b0;
      end else begin
         if (o_ex0_ready) ex0_vld_q <= i_issue_valid;
         if (ex1_free) ex1_vld_q <= ex0_vld_q;
         if (ex2_free) ex2_vld_q <= ex1_vld_q;
         ex3_vld_q <= ex2_adv;
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_ex0_ready) ex0_q <= i_issue;
      if (ex1_free) ex1_q <= ex0_q;
      if (ex2_free) ex2_q <= ex1_ex2;
      if (ex2_adv) begin
         ex3_q.op     <= ex2_q.op;
         ex3_q.rob_id <= ex2_q.rob_id;
         ex3_q.rd_tag <= ex2_q.rd_tag;
         ex3_q.data   <= i_resp.rdata;
         if (ex2_q.misal) ex3_q.exc <= MISALIGNED;
         else if (i_resp.err) ex3_q.exc <= ACCESS_FAULT;
         else ex3_q.exc <= NONE;
      end
   end

   // ============================================================
   // Memory request and completion
   // ============================================================
   assign o_mem_req_valid = ex2_vld_q && !ex2_q.misal;
   assign o_mem_req.addr  = ex2_q.addr;
   assign o_mem_req.write = (ex2_q.op == STORE);
   assign o_mem_req.wdata = ex2_q.st_data;

   assign o_ex3_phy_wr.valid = ex3_vld_q && ex3_q.op == LOAD && ex3_q.exc == NONE;
   assign o_ex3_phy_wr.tag   = ex3_q.rd_tag;
   assign o_ex3_phy_wr.data  = ex3_q.data;

   assign o_done.valid  = ex3_vld_q;
   assign o_done.rob_id = ex3_q.rob_id;
   assign o_done.exc    = ex3_q.exc;

   a_req_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      (o_mem_req_valid && !i_resp_valid) |=> (o_mem_req_valid && $stable(o_mem_req)));

endmodule

`default_nettype wire

//--- src/lsu_apb_master.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_apb_master (
   input  logic                      i_clk,
   input  logic                      i_rst,
   input  logic                      i_req_valid,
   input  lsu_pkg::mem_req_t         i_req,
   output logic                      o_resp_valid,
   output lsu_pkg::mem_resp_t        o_resp,
   output logic                      o_psel,
   output logic                      o_penable,
   output logic [lsu_pkg::XLEN-1:0]  o_paddr,
   output logic                      o_pwrite,
   output logic [lsu_pkg::XLEN-1:0]  o_pwdata,
   input  logic                      i_pready,
   input  logic [lsu_pkg::XLEN-1:0]  i_prdata,
   input  logic                      i_pslverr
);
   import lsu_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SETUP,
      ST_ACCESS
   } apb_state_e;

   apb_state_e state_q;
   logic       accept;
   logic       finish;

   // Requester holds valid through the response cycle
   assign accept = (state_q == ST_IDLE) && i_req_valid && !o_resp_valid;
   assign finish = (state_q == ST_ACCESS) && i_pready;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q      <= ST_IDLE;
         o_psel       <= 1'b0;
         o_penable    <= 1'b0;
         o_resp_valid <= 1'b0;
      end else begin
         o_resp_valid <= finish;
         case (state_q)
            ST_IDLE: begin
               if (accept) begin
                  state_q <= ST_SETUP;
                  o_psel  <= 1'b1;
               end
            end
            ST_SETUP: begin
               state_q   <= ST_ACCESS;
               o_penable <= 1'b1;
            end
            ST_ACCESS: begin
               if (i_pready) begin
                  state_q   <= ST_IDLE;
                  o_psel    <= 1'b0;
                  o_penable <= 1'b0;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (accept) begin
         o_paddr  <= i_req.addr;
         o_pwrite <= i_req.write;
         o_pwdata <= i_req.wdata;
      end
      if (finish) begin
         o_resp.rdata <= i_prdata;
         o_resp.err   <= i_pslverr;
      end
   end

   a_penable_psel: assert property (@(posedge i_clk) disable iff (i_rst)
      o_penable |-> o_psel);

   a_addr_stable: assert property (@(posedge i_clk) disable iff (i_rst)
      (o_psel && !(o_penable && i_pready)) |=>
         ($stable(o_paddr) && $stable(o_pwrite) && $stable(o_pwdata)));

   a_resp_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
      o_resp_valid |=> !o_resp_valid);

endmodule

`default_nettype wire

//--- src/lsu_cluster.sv
`default_nettype none
`timescale 1ns/1ps

module lsu_cluster (
   input  logic                      i_clk,
   input  logic                      i_rst,
   // Dispatch
   input  logic                      i_disp_valid,
   input  lsu_pkg::lsu_disp_t        i_disp,
   output logic                      o_disp_ready,
   // Result broadcast
   input  lsu_pkg::phy_wr_t          i_phy_wr,
   output lsu_pkg::phy_wr_t          o_ex3_phy_wr,
   output lsu_pkg::lsu_done_t        o_done,
   // APB
   output logic                      o_psel,
   output logic                      o_penable,
   output logic [lsu_pkg::XLEN-1:0]  o_paddr,
   output logic                      o_pwrite,
   output logic [lsu_pkg::XLEN-1:0]  o_pwdata,
   input  logic                      i_pready,
   input  logic [lsu_pkg::XLEN-1:0]  i_prdata,
   input  logic                      i_pslverr
);
   import lsu_pkg::*;

   logic       issue_valid;
   lsu_issue_t issue;
   logic       ex0_ready;
   logic       mem_req_valid;
   mem_req_t   mem_req;
   logic       resp_valid;
   mem_resp_t  resp;
   phy_wr_t    ex3_phy_wr;

   // ============================================================
   // Scheduler with own load results looped back as wakeups
   // ============================================================
   lsu_sched u_lsu_sched (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_disp_valid  (i_disp_valid),
      .i_disp        (i_disp),
      .o_disp_ready  (o_disp_ready),
      .i_phy_wr      (i_phy_wr),
      .i_self_wr     (ex3_phy_wr),
      .o_issue_valid (issue_valid),
      .o_issue       (issue),
      .i_issue_ready (ex0_ready)
   );

   lsu_pipe u_lsu_pipe (
      .i_clk           (i_clk),
      .i_rst           (i_rst),
      .i_issue_valid   (issue_valid),
      .i_issue         (issue),
      .o_ex0_ready     (ex0_ready),
      .o_mem_req_valid (mem_req_valid),
      .o_mem_req       (mem_req),
      .i_resp_valid    (resp_valid),
      .i_resp          (resp),
      .o_ex3_phy_wr    (ex3_phy_wr),
      .o_done          (o_done)
   );

   lsu_apb_master u_lsu_apb_master (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_req_valid  (mem_req_valid),
      .i_req        (mem_req),
      .o_resp_valid (resp_valid),
      .o_resp       (resp),
      .o_psel       (o_psel),
      .o_penable    (o_penable),
      .o_paddr      (o_paddr),
      .o_pwrite     (o_pwrite),
      .o_pwdata     (o_pwdata),
      .i_pready     (i_pready),
      .i_prdata     (i_prdata),
      .i_pslverr    (i_pslverr)
   );

   assign o_ex3_phy_wr = ex3_phy_wr;

endmodule

`default_nettype wire

//--- tb/tb_lsu_tasks.svh
// ============================================================
// Stimulus builders
// ============================================================
function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
   return {addr[15:0] ^ 16'h5a5a, addr[15:0]};
endfunction

function automatic lsu_disp_t make_disp(input lsu_op_e op, input logic [ROB_W-1:0] rob,
                                        input logic [TAG_W-1:0] rd, input logic base_rdy,
                                        input logic [TAG_W-1:0] base_tag,
                                        input logic [XLEN-1:0] base,
                                        input logic [XLEN-1:0] st_data,
                                        input logic [11:0] imm);
   lsu_disp_t d;
   d.op        = op;
   d.rob_id    = rob;
   d.rd_tag    = rd;
   d.rs1.ready = base_rdy;
   d.rs1.tag   = base_tag;
   d.rs1.value = base_rdy ? base : '0;
   d.rs2.ready = 1'b1;
   d.rs2.tag   = '0;
   d.rs2.value = st_data;
   d.imm       = imm;
   return d;
endfunction

function automatic lsu_done_t make_done(input logic [ROB_W-1:0] rob, input lsu_exc_e exc);
   lsu_done_t d;
   d.valid  = 1'b1;
   d.rob_id = rob;
   d.exc    = exc;
   return d;
endfunction

function automatic phy_wr_t make_wr(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] data);
   phy_wr_t w;
   w.valid = 1'b1;
   w.tag   = tag;
   w.data  = data;
   return w;
endfunction

// ============================================================
// Compare tasks
// ============================================================
task automatic check_done(input lsu_done_t got, input lsu_done_t exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("error o_done got %h expected %h", got, exp);
   end
endtask

task automatic check_phy_wr(input phy_wr_t got, input phy_wr_t exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("error o_ex3_phy_wr got %h expected %h", got, exp);
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("error %s got %h expected %h", name, got, exp);
   end
endtask

task automatic check_quiet(input string what, input int seen);
   checks++;
   if (seen != 0) begin
      errors++;
      $display("%s: saw %0d where none were expected", what, seen);
   end
endtask

task automatic take_done(input lsu_done_t exp);
   lsu_done_t got;
   if (done_q.size() == 0) begin
      errors++;
      $display("no completion arrived for rob %0d", exp.rob_id);
   end else begin
      got = done_q.pop_front();
      check_done(got, exp);
   end
endtask

task automatic take_wr(input phy_wr_t exp);
   phy_wr_t got;
   if (wr_q.size() == 0) begin
      errors++;
      $display("no register write arrived for tag %0d", exp.tag);
   end else begin
      got = wr_q.pop_front();
      check_phy_wr(got, exp);
   end
endtask

// ============================================================
// Drivers and waits
// ============================================================
task automatic clear_logs();
   done_q.delete();
   wr_q.delete();
   setups = 0;
endtask

task automatic dispatch(input lsu_disp_t d);
   int waited;
   waited = 0;
   @(posedge clk);
   disp_valid <= 1'b1;
   disp       <= d;
   @(negedge clk);
   while (!disp_ready && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
   end
   if (!disp_ready) begin
      errors++;
      $display("dispatch of rob %0d was never accepted", d.rob_id);
   end
   @(posedge clk);
   disp_valid <= 1'b0;
endtask

task automatic broadcast(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] data);
   @(posedge clk);
   phy_wr <= make_wr(tag, data);
   @(posedge clk);
   phy_wr <= '0;
endtask

task automatic wait_dones(input int n);
   int waited;
   waited = 0;
   while (done_q.size() < n && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
   end
   if (done_q.size() < n) begin
      errors++;
      $display("timed out waiting for %0d completions, saw %0d", n, done_q.size());
   end
endtask

// ============================================================
// Directed tests
// ============================================================
task automatic test_reset_state();
   @(negedge clk);
   check_flag("o_disp_ready", disp_ready, 1'b1);
   check_flag("o_psel", psel, 1'b0);
   check_flag("o_penable", penable, 1'b0);
   check_flag("o_done.valid", done.valid, 1'b0);
   check_flag("o_ex3_phy_wr.valid", ex3_phy_wr.valid, 1'b0);
endtask

task automatic test_load_ready();
   clear_logs();
   dispatch(make_disp(LOAD, 4'd1, 5'd1, 1'b1, 5'd0, 32'h30, '0, 12'h010));
   wait_dones(1);
   take_done(make_done(4'd1, NONE));
   take_wr(make_wr(5'd1, mem_word(32'h40)));
endtask

task automatic test_store_load();
   clear_logs();
   dispatch(make_disp(STORE, 4'd2, 5'd0, 1'b1, 5'd0, 32'h70, 32'hcafe_1234, 12'h010));
   wait_dones(1);
   take_done(make_done(4'd2, NONE));
   check_quiet("register writes from a store", wr_q.size());
   clear_logs();
   // Negative offset back onto the stored word
   dispatch(make_disp(LOAD, 4'd3, 5'd2, 1'b1, 5'd0, 32'h90, '0, 12'hff0));
   wait_dones(1);
   take_done(make_done(4'd3, NONE));
   take_wr(make_wr(5'd2, 32'hcafe_1234));
endtask

task automatic test_wakeup();
   clear_logs();
   dispatch(make_disp(LOAD, 4'd4, 5'd3, 1'b0, 5'd9, '0, '0, 12'h004));
   repeat (20) @(posedge clk);
   check_quiet("completions before the base was ready", done_q.size());
   broadcast(5'd9, 32'h20);
   wait_dones(1);
   take_done(make_done(4'd4, NONE));
   take_wr(make_wr(5'd3, mem_word(32'h24)));
endtask

task automatic test_misaligned();
   clear_logs();
   dispatch(make_disp(LOAD, 4'd5, 5'd4, 1'b1, 5'd0, 32'h10, '0, 12'h002));
   wait_dones(1);
   take_done(make_done(4'd5, MISALIGNED));
   check_quiet("APB transfers for a misaligned load", setups);
   check_quiet("register writes from a misaligned load", wr_q.size());
endtask

task automatic test_access_fault();
   clear_logs();
   dispatch(make_disp(LOAD, 4'd6, 5'd5, 1'b1, 5'd0, 32'h100, '0, 12'h008));
   wait_dones(1);
   take_done(make_done(4'd6, ACCESS_FAULT));
   check_quiet("register writes from a faulting load", wr_q.size());
endtask

task automatic test_backpressure();
   clear_logs();
   for (int i = 0; i < 4; i++) begin
      dispatch(make_disp(LOAD, ROB_W'(8 + i), TAG_W'(20 + i), 1'b0, 5'd12, '0, '0,
                         12'(4 * i)));
   end
   // Long enough for an early issue to reach completion
   repeat (20) @(posedge clk);
   @(negedge clk);
   check_flag("o_disp_ready", disp_ready, 1'b0);
   check_quiet("completions before the shared base was ready", done_q.size());
   broadcast(5'd12, 32'h60);
   wait_dones(4);
   // Window for duplicates
   repeat (10) @(posedge clk);
   checks++;
   if (done_q.size() != 4) begin
      errors++;
      $display("expected 4 completions after wakeup, saw %0d", done_q.size());
   end
   for (int i = 0; i < 4; i++) begin
      take_done(make_done(ROB_W'(8 + i), NONE));
      take_wr(make_wr(TAG_W'(20 + i), mem_word(32'h60 + 4 * i)));
   end
endtask

//--- tb/tb_lsu_cluster.sv
`default_nettype none
`timescale 1ns/1ps

module tb_lsu_cluster;
   import lsu_pkg::*;

   localparam int WAIT_LIMIT = 200;

   logic            clk;
   logic            rst;
   logic            disp_valid;
   lsu_disp_t       disp;
   logic            disp_ready;
   phy_wr_t         phy_wr;
   phy_wr_t         ex3_phy_wr;
   lsu_done_t       done;
   logic            psel;
   logic            penable;
   logic [XLEN-1:0] paddr;
   logic            pwrite;
   logic [XLEN-1:0] pwdata;
   logic            pready;
   logic [XLEN-1:0] prdata;
   logic            pslverr;

   // APB slave model state
   logic [XLEN-1:0] mem [64];
   logic [1:0]      wait_left;
   logic [1:0]      draw;
   integer          seed;

   int              errors;
   int              checks;
   int              setups;
   lsu_done_t       done_q [$];
   phy_wr_t         wr_q [$];

   `include "tb_lsu_tasks.svh"

   lsu_cluster i_lsu_cluster (
      .i_clk        (clk),
      .i_rst        (rst),
      .i_disp_valid (disp_valid),
      .i_disp       (disp),
      .o_disp_ready (disp_ready),
      .i_phy_wr     (phy_wr),
      .o_ex3_phy_wr (ex3_phy_wr),
      .o_done       (done),
      .o_psel       (psel),
      .o_penable    (penable),
      .o_paddr      (paddr),
      .o_pwrite     (pwrite),
      .o_pwdata     (pwdata),
      .i_pready     (pready),
      .i_prdata     (prdata),
      .i_pslverr    (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ============================================================
   // APB slave of 64 words that faults at 0x100 and above
   // ============================================================
   task present_response();
      pready  <= 1'b1;
      prdata  <= mem[paddr[7:2]];
      pslverr <= (paddr >= 32'h100);
   endtask

   always @(posedge clk) begin
      if (rst) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else if (psel && !penable) begin
         // Pick 0 to 3 wait states in the setup phase
         draw = 2'($random(seed));
         wait_left <= draw;
         if (draw == 2'd0) present_response();
      end else if (psel && penable && pready) begin
         pready <= 1'b0;
         if (pwrite && paddr < 32'h100) mem[paddr[7:2]] <= pwdata;
      end else if (psel && penable) begin
         wait_left <= wait_left - 1'b1;
         if (wait_left == 2'd1) present_response();
      end
   end

   // Outputs are stable mid-cycle
   always @(negedge clk) begin
      if (!rst) begin
         if (done.valid) done_q.push_back(done);
         if (ex3_phy_wr.valid) wr_q.push_back(ex3_phy_wr);
         if (psel && !penable) setups++;
      end
   end

   initial begin
      seed       = 3022;
      errors     = 0;
      checks     = 0;
      setups     = 0;
      rst        = 1'b1;
      disp_valid = 1'b0;
      disp       = '0;
      phy_wr     = '0;
      pready     = 1'b0;
      prdata     = '0;
      pslverr    = 1'b0;
      wait_left  = '0;
      for (int i = 0; i < 64; i++) mem[i] = mem_word(i * 4);
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      test_reset_state();
      test_load_ready();
      test_store_load();
      test_wakeup();
      test_misaligned();
      test_access_fault();
      test_backpressure();

      repeat (4) @(posedge clk);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- lsu_cluster.f
+incdir+tb
src/lsu_pkg.sv
src/lsu_sched.sv
src/lsu_pipe.sv
src/lsu_apb_master.sv
src/lsu_cluster.sv
tb/tb_lsu_cluster.sv
